// File: source/axi_params_pkg.sv
package axi_params_pkg;

    // PS channel widths
    localparam int A_BUS_WIDTH     = 16;
    localparam int WD_BUS_WIDTH    = 32;
    localparam int RESP_DATA_WIDTH = 2;

    // response codes, AXI encoding
    localparam logic [RESP_DATA_WIDTH-1:0] RESP_OKAY   = 2'd0;
    localparam logic [RESP_DATA_WIDTH-1:0] RESP_SLVERR = 2'd2;

    // one register access as seen by the bank port
    typedef struct packed {
        // set for writes, clear for reads
        logic                    we;
        // byte address, word aligned
        logic [A_BUS_WIDTH-1:0]  addr;
        // ignored on reads
        logic [WD_BUS_WIDTH-1:0] wdata;
    } reg_req_t;

    // bank answer, valid the cycle after the access
    typedef struct packed {
        // zero for writes and for failed reads
        logic [WD_BUS_WIDTH-1:0]    rdata;
        logic [RESP_DATA_WIDTH-1:0] resp;
    } reg_rsp_t;

endpackage

// File: source/daq_params_pkg.sv
package daq_params_pkg;

    // generator array
    localparam int DAC_NUM           = 2;
    localparam int SAMPLE_WIDTH      = 16;
    localparam int SAMPLES_PER_BATCH = 4;
    localparam int BATCH_WIDTH       = SAMPLE_WIDTH * SAMPLES_PER_BATCH;

    // galois feedback mask, right shifting
    localparam logic [SAMPLE_WIDTH-1:0] LFSR_TAPS = 16'hB400;

    // pl_rstn low pulse length and its counter
    localparam int PL_RST_CYCLES = 16;
    localparam int RST_CNT_WIDTH = $clog2(PL_RST_CYCLES + 1);

    // identity word
    localparam logic [31:0] DAQ_ID = 32'hDA0C_0001;

    // register map, byte addresses
    localparam int ADDR_RST_CMD = 'h00;
    localparam int ADDR_ID      = 'h04;
    localparam int DAC_BASE     = 'h10;
    localparam int DAC_STRIDE   = 'h10;
    // per dac offsets
    localparam int MODE_OFS     = 'h0;
    localparam int SEED_OFS     = 'h4;
    localparam int STEP_OFS     = 'h8;

    // generator modes, 3 acts as off
    localparam int MODE_WIDTH = 2;
    localparam logic [MODE_WIDTH-1:0] MODE_OFF  = 2'd0;
    localparam logic [MODE_WIDTH-1:0] MODE_RAMP = 2'd1;
    localparam logic [MODE_WIDTH-1:0] MODE_LFSR = 2'd2;

    // one generator's configuration
    typedef struct packed {
        logic [MODE_WIDTH-1:0]   mode;
        logic [SAMPLE_WIDTH-1:0] seed;
        // ramp increment per sample
        logic [SAMPLE_WIDTH-1:0] step;
    } dac_cfg_t;

endpackage

// File: source/axi_write_slave.sv
`timescale 1ns/10ps

module axi_write_slave import axi_params_pkg::*; (
    input  wire                        ps_clk,
    input  wire                        rst,
    input  wire [A_BUS_WIDTH-1:0]      waddr_packet,
    input  wire                        waddr_valid_packet,
    input  wire [WD_BUS_WIDTH-1:0]     wdata_packet,
    input  wire                        wdata_valid_packet,
    input  wire                        ps_wresp_rdy,
    input  wire                        grant,
    input  reg_rsp_t                   rsp,
    output logic                       req_valid,
    output reg_req_t                   req,
    output logic [RESP_DATA_WIDTH-1:0] wresp_out,
    output logic                       wresp_valid_out
);

    logic                       addr_held;
    logic                       data_held;
    logic [A_BUS_WIDTH-1:0]     addr_q;
    logic [WD_BUS_WIDTH-1:0]    data_q;
    // bank answer arrives this cycle
    logic                       rsp_first;
    logic [RESP_DATA_WIDTH-1:0] resp_q;

    // control flags
    always_ff @(posedge ps_clk) begin
        if (rst) begin
            addr_held       <= 1'b0;
            data_held       <= 1'b0;
            rsp_first       <= 1'b0;
            wresp_valid_out <= 1'b0;
        end else begin
            rsp_first <= grant;
            if (grant) begin
                // access done at this edge, response follows
                addr_held       <= 1'b0;
                data_held       <= 1'b0;
                wresp_valid_out <= 1'b1;
            end else begin
                // packets ignored while a response is pending
                if (waddr_valid_packet && !wresp_valid_out)
                    addr_held <= 1'b1;
                if (wdata_valid_packet && !wresp_valid_out)
                    data_held <= 1'b1;
                if (ps_wresp_rdy)
                    wresp_valid_out <= 1'b0;
            end
        end
    end

    // packet payloads, first strobe wins
    always_ff @(posedge ps_clk) begin
        if (waddr_valid_packet && !addr_held && !wresp_valid_out)
            addr_q <= waddr_packet;
        if (wdata_valid_packet && !data_held && !wresp_valid_out)
            data_q <= wdata_packet;
        if (rsp_first)
            resp_q <= rsp.resp;
    end

    // request once both halves are in
    always_comb begin
        req_valid = addr_held && data_held;
        req.we    = 1'b1;
        req.addr  = addr_q;
        req.wdata = data_q;
    end

    // live code in the first cycle, latched copy after
    assign wresp_out = rsp_first ? rsp.resp : resp_q;

endmodule

// File: source/axi_read_slave.sv
`timescale 1ns/10ps

module axi_read_slave import axi_params_pkg::*; (
    input  wire                        ps_clk,
    input  wire                        rst,
    input  wire [A_BUS_WIDTH-1:0]      raddr_packet,
    input  wire                        raddr_valid_packet,
    input  wire                        ps_read_rdy,
    input  wire                        grant,
    input  reg_rsp_t                   rsp,
    output logic                       req_valid,
    output reg_req_t                   req,
    output logic [WD_BUS_WIDTH-1:0]    rdata_packet,
    output logic                       rdata_valid_out,
    output logic [RESP_DATA_WIDTH-1:0] rresp_out,
    output logic                       rresp_valid_out
);

    logic                   addr_held;
    logic [A_BUS_WIDTH-1:0] addr_q;
    // data and response share one valid
    logic                   resp_valid;
    logic                   rsp_first;
    reg_rsp_t               rsp_q;

    always_ff @(posedge ps_clk) begin
        if (rst) begin
            addr_held  <= 1'b0;
            resp_valid <= 1'b0;
            rsp_first  <= 1'b0;
        end else begin
            rsp_first <= grant;
            if (grant) begin
                addr_held  <= 1'b0;
                resp_valid <= 1'b1;
            end else begin
                // new address only when idle
                if (raddr_valid_packet && !resp_valid)
                    addr_held <= 1'b1;
                if (ps_read_rdy)
                    resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (raddr_valid_packet && !addr_held && !resp_valid)
            addr_q <= raddr_packet;
        // keep the answer for the rest of the hold
        if (rsp_first)
            rsp_q <= rsp;
    end

    always_comb begin
        req_valid = addr_held;
        req.we    = 1'b0;
        req.addr  = addr_q;
        req.wdata = '0;
    end

    assign rdata_packet    = rsp_first ? rsp.rdata : rsp_q.rdata;
    assign rresp_out       = rsp_first ? rsp.resp : rsp_q.resp;
    assign rdata_valid_out = resp_valid;
    assign rresp_valid_out = resp_valid;

endmodule

// File: source/reg_bus_arbiter.sv
`timescale 1ns/10ps

module reg_bus_arbiter import axi_params_pkg::*; (
    input  wire      ps_clk,
    input  wire      rst,
    input  wire      wr_req_valid,
    input  reg_req_t wr_req,
    input  wire      rd_req_valid,
    input  reg_req_t rd_req,
    input  reg_rsp_t bank_rsp,
    output logic     wr_grant,
    output logic     rd_grant,
    output logic     bank_req_valid,
    output reg_req_t bank_req,
    output reg_rsp_t wr_rsp,
    output reg_rsp_t rd_rsp
);

    // writer won the last contested or uncontested grant
    logic last_wr;
    // writer owns the bank answer of this cycle
    logic owner_wr;

    // same cycle grant, loser of last round first on contention
    always_comb begin
        wr_grant       = wr_req_valid && (!rd_req_valid || !last_wr);
        rd_grant       = rd_req_valid && !wr_grant;
        bank_req_valid = wr_grant || rd_grant;
        bank_req       = wr_grant ? wr_req : rd_req;
    end

    always_ff @(posedge ps_clk) begin
        if (rst) begin
            last_wr  <= 1'b0;
            owner_wr <= 1'b0;
        end else begin
            if (bank_req_valid)
                last_wr <= wr_grant;
            owner_wr <= wr_grant;
        end
    end

    // steer answer to whoever was granted one cycle back
    always_comb begin
        wr_rsp = '0;
        rd_rsp = '0;
        if (owner_wr)
            wr_rsp = bank_rsp;
        else
            rd_rsp = bank_rsp;
    end

endmodule

// File: source/daq_reg_bank.sv
`timescale 1ns/10ps

module daq_reg_bank import axi_params_pkg::*, daq_params_pkg::*; (
    input  wire                     ps_clk,
    input  wire                     rst,
    input  wire                     req_valid,
    input  reg_req_t                req,
    output reg_rsp_t                rsp,
    output dac_cfg_t [DAC_NUM-1:0]  dac_cfg,
    output logic [DAC_NUM-1:0]      dac_reload,
    output logic                    pl_rstn
);

    // address decode
    logic [DAC_NUM-1:0]       sel_mode;
    logic [DAC_NUM-1:0]       sel_seed;
    logic [DAC_NUM-1:0]       sel_step;
    logic                     sel_rst;
    logic                     sel_id;
    logic                     wr_ok;
    logic                     rd_ok;
    logic [WD_BUS_WIDTH-1:0]  rd_data;
    // per dac write seen last edge
    logic [DAC_NUM-1:0]       wr_hit;
    logic [RST_CNT_WIDTH-1:0] rst_cnt;

    always_comb begin
        int dac_base;
        sel_rst = (req.addr == A_BUS_WIDTH'(ADDR_RST_CMD));
        sel_id  = (req.addr == A_BUS_WIDTH'(ADDR_ID));
        rd_data = '0;
        if (sel_id)
            rd_data = DAQ_ID;
        for (int i = 0; i < DAC_NUM; i++) begin
            dac_base    = DAC_BASE + i * DAC_STRIDE;
            sel_mode[i] = (req.addr == A_BUS_WIDTH'(dac_base + MODE_OFS));
            sel_seed[i] = (req.addr == A_BUS_WIDTH'(dac_base + SEED_OFS));
            sel_step[i] = (req.addr == A_BUS_WIDTH'(dac_base + STEP_OFS));
            // fields zero extended on read
            if (sel_mode[i])
                rd_data = WD_BUS_WIDTH'(dac_cfg[i].mode);
            if (sel_seed[i])
                rd_data = WD_BUS_WIDTH'(dac_cfg[i].seed);
            if (sel_step[i])
                rd_data = WD_BUS_WIDTH'(dac_cfg[i].step);
        end
        // rst cmd is write only, id read only
        wr_ok = sel_rst || (|sel_mode) || (|sel_seed) || (|sel_step);
        rd_ok = sel_id || (|sel_mode) || (|sel_seed) || (|sel_step);
    end

    // config fields, reset command and reload detect
    always_ff @(posedge ps_clk) begin
        if (rst) begin
            for (int i = 0; i < DAC_NUM; i++) begin
                dac_cfg[i].mode <= MODE_OFF;
                dac_cfg[i].seed <= '0;
                dac_cfg[i].step <= '0;
            end
            wr_hit  <= '0;
            rst_cnt <= '0;
        end else begin
            for (int i = 0; i < DAC_NUM; i++) begin
                wr_hit[i] <= req_valid && req.we && (sel_mode[i] || sel_seed[i] || sel_step[i]);
                if (req_valid && req.we && sel_mode[i])
                    dac_cfg[i].mode <= req.wdata[MODE_WIDTH-1:0];
                if (req_valid && req.we && sel_seed[i])
                    dac_cfg[i].seed <= req.wdata[SAMPLE_WIDTH-1:0];
                if (req_valid && req.we && sel_step[i])
                    dac_cfg[i].step <= req.wdata[SAMPLE_WIDTH-1:0];
            end
            // countdown, pl_rstn low while nonzero
            if (req_valid && req.we && sel_rst)
                rst_cnt <= RST_CNT_WIDTH'(PL_RST_CYCLES);
            else if (rst_cnt != '0)
                rst_cnt <= rst_cnt - 1'b1;
        end
    end

    // answer registered for the cycle after the access
    always_ff @(posedge ps_clk) begin
        if (req_valid) begin
            rsp.rdata <= req.we ? '0 : rd_data;
            rsp.resp  <= (req.we ? wr_ok : rd_ok) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign pl_rstn = (rst_cnt == '0);

    // whole array reloads during the pulse
    assign dac_reload = wr_hit | {DAC_NUM{!pl_rstn}};

endmodule

// File: source/dac_sample_gen.sv
`timescale 1ns/10ps

module dac_sample_gen import daq_params_pkg::*; (
    input  wire                    ps_clk,
    input  wire                    rst,
    input  dac_cfg_t               cfg,
    input  wire                    reload,
    input  wire                    dac_rdy,
    output logic [BATCH_WIDTH-1:0] batch,
    output logic                   batch_valid
);

    // first sample base for ramp, shift register for lfsr
    logic [SAMPLE_WIDTH-1:0] state;
    logic [SAMPLE_WIDTH-1:0] next_state;
    logic                    run_ramp;
    logic                    run_lfsr;

    assign run_ramp = (cfg.mode == MODE_RAMP);
    assign run_lfsr = (cfg.mode == MODE_LFSR);

    // off and mode 3 give no output
    assign batch_valid = !reload && (run_ramp || run_lfsr);

    // unrolled batch, sample 0 in the low bits
    always_comb begin
        logic [SAMPLE_WIDTH-1:0] ramp;
        logic [SAMPLE_WIDTH-1:0] lfsr;
        ramp  = state;
        lfsr  = state;
        batch = '0;
        for (int k = 0; k < SAMPLES_PER_BATCH; k++) begin
            // galois step, feedback on the bit shifted out
            lfsr = {1'b0, lfsr[SAMPLE_WIDTH-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
            if (run_lfsr)
                batch[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lfsr;
            else
                batch[k*SAMPLE_WIDTH +: SAMPLE_WIDTH] = ramp;
            // wraps mod 2^16
            ramp = ramp + cfg.step;
        end
        // ramp ends one batch ahead, lfsr on its last sample
        next_state = run_lfsr ? lfsr : ramp;
    end

    always_ff @(posedge ps_clk) begin
        if (rst)
            state <= '0;
        else if (reload)
            state <= cfg.seed;
        // advance only on an accepted batch
        else if (batch_valid && dac_rdy)
            state <= next_state;
    end

endmodule

// File: source/daq_top.sv
`timescale 1ns/10ps

module daq_top import axi_params_pkg::*, daq_params_pkg::*; (
    input  wire                                  ps_clk,
    input  wire                                  rst,
    // dac side
    input  wire [DAC_NUM-1:0]                    dac_rdys,
    output logic [DAC_NUM-1:0][BATCH_WIDTH-1:0]  dac_batches,
    output logic [DAC_NUM-1:0]                   valid_dac_batches,
    output logic                                 pl_rstn,
    // ps side
    input  wire [A_BUS_WIDTH-1:0]                raddr_packet,
    input  wire                                  raddr_valid_packet,
    input  wire [A_BUS_WIDTH-1:0]                waddr_packet,
    input  wire                                  waddr_valid_packet,
    input  wire [WD_BUS_WIDTH-1:0]               wdata_packet,
    input  wire                                  wdata_valid_packet,
    input  wire                                  ps_wresp_rdy,
    input  wire                                  ps_read_rdy,
    output logic [RESP_DATA_WIDTH-1:0]           wresp_out,
    output logic                                 wresp_valid_out,
    output logic [RESP_DATA_WIDTH-1:0]           rresp_out,
    output logic                                 rresp_valid_out,
    output logic [WD_BUS_WIDTH-1:0]              rdata_packet,
    output logic                                 rdata_valid_out
);

    // handler to arbiter
    logic     wr_req_valid;
    logic     rd_req_valid;
    reg_req_t wr_req;
    reg_req_t rd_req;
    logic     wr_grant;
    logic     rd_grant;
    reg_rsp_t wr_rsp;
    reg_rsp_t rd_rsp;
    // arbiter to bank
    logic     bank_req_valid;
    reg_req_t bank_req;
    reg_rsp_t bank_rsp;
    // bank to generators
    dac_cfg_t [DAC_NUM-1:0] dac_cfg;
    logic [DAC_NUM-1:0]     dac_reload;

    axi_write_slave i_axi_write_slave (
        .ps_clk(ps_clk), .rst(rst),
        .waddr_packet(waddr_packet), .waddr_valid_packet(waddr_valid_packet),
        .wdata_packet(wdata_packet), .wdata_valid_packet(wdata_valid_packet),
        .ps_wresp_rdy(ps_wresp_rdy), .grant(wr_grant), .rsp(wr_rsp),
        .req_valid(wr_req_valid), .req(wr_req),
        .wresp_out(wresp_out), .wresp_valid_out(wresp_valid_out)
    );

    axi_read_slave i_axi_read_slave (
        .ps_clk(ps_clk), .rst(rst),
        .raddr_packet(raddr_packet), .raddr_valid_packet(raddr_valid_packet),
        .ps_read_rdy(ps_read_rdy), .grant(rd_grant), .rsp(rd_rsp),
        .req_valid(rd_req_valid), .req(rd_req),
        .rdata_packet(rdata_packet), .rdata_valid_out(rdata_valid_out),
        .rresp_out(rresp_out), .rresp_valid_out(rresp_valid_out)
    );

    reg_bus_arbiter i_reg_bus_arbiter (
        .ps_clk(ps_clk), .rst(rst),
        .wr_req_valid(wr_req_valid), .wr_req(wr_req),
        .rd_req_valid(rd_req_valid), .rd_req(rd_req),
        .bank_rsp(bank_rsp),
        .wr_grant(wr_grant), .rd_grant(rd_grant),
        .bank_req_valid(bank_req_valid), .bank_req(bank_req),
        .wr_rsp(wr_rsp), .rd_rsp(rd_rsp)
    );

    daq_reg_bank i_daq_reg_bank (
        .ps_clk(ps_clk), .rst(rst),
        .req_valid(bank_req_valid), .req(bank_req), .rsp(bank_rsp),
        .dac_cfg(dac_cfg), .dac_reload(dac_reload), .pl_rstn(pl_rstn)
    );

    // one generator per dac channel
    for (genvar i = 0; i < DAC_NUM; i++) begin : g_dac
        dac_sample_gen i_dac_sample_gen (
            .ps_clk(ps_clk), .rst(rst),
            .cfg(dac_cfg[i]), .reload(dac_reload[i]), .dac_rdy(dac_rdys[i]),
            .batch(dac_batches[i]), .batch_valid(valid_dac_batches[i])
        );
    end

endmodule

// File: testbench/daq_tb_table.svh
`ifndef DAQ_TB_TABLE_SVH
`define DAQ_TB_TABLE_SVH

// generator settings used by the table and the batch model
localparam logic [15:0] RAMP_SEED = 16'h1234;
localparam logic [15:0] RAMP_STEP = 16'h0007;
localparam logic [15:0] LFSR_SEED = 16'hACE1;

localparam logic [1:0] OP_WR   = 2'd0;
localparam logic [1:0] OP_RD   = 2'd1;
// write to addr and read from raddr strobed together
localparam logic [1:0] OP_BOTH = 2'd2;

localparam logic [1:0] ORD_ADDR_FIRST = 2'd0;
localparam logic [1:0] ORD_DATA_FIRST = 2'd1;
localparam logic [1:0] ORD_SAME       = 2'd2;

typedef struct packed {
    logic [1:0]  op;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [15:0] raddr;
    logic [1:0]  order;
    // base ready delay, random cycles are added
    logic [3:0]  delay;
    logic [1:0]  exp_resp;
    logic [31:0] exp_rdata;
} tb_row_t;

localparam int N_ROWS = 19;

// op, addr, wdata, raddr, order, delay, expected resp, expected read data
tb_row_t ops_table [N_ROWS] = '{
    '{OP_RD,   16'h0004, 32'h0,           16'h0,    ORD_SAME,       4'd1, 2'd0, 32'hDA0C_0001},
    '{OP_WR,   16'h0010, 32'h0000_0005,   16'h0,    ORD_ADDR_FIRST, 4'd0, 2'd0, 32'h0},
    '{OP_RD,   16'h0010, 32'h0,           16'h0,    ORD_SAME,       4'd2, 2'd0, 32'h0000_0001},
    '{OP_WR,   16'h0014, 32'hABCD_1234,   16'h0,    ORD_DATA_FIRST, 4'd1, 2'd0, 32'h0},
    '{OP_RD,   16'h0014, 32'h0,           16'h0,    ORD_SAME,       4'd0, 2'd0, 32'h0000_1234},
    '{OP_WR,   16'h0018, 32'h0003_0007,   16'h0,    ORD_SAME,       4'd3, 2'd0, 32'h0},
    '{OP_RD,   16'h0018, 32'h0,           16'h0,    ORD_SAME,       4'd1, 2'd0, 32'h0000_0007},
    '{OP_WR,   16'h0020, 32'h0000_0002,   16'h0,    ORD_ADDR_FIRST, 4'd2, 2'd0, 32'h0},
    '{OP_RD,   16'h0020, 32'h0,           16'h0,    ORD_SAME,       4'd0, 2'd0, 32'h0000_0002},
    '{OP_WR,   16'h0024, 32'h0000_ACE1,   16'h0,    ORD_DATA_FIRST, 4'd0, 2'd0, 32'h0},
    '{OP_RD,   16'h0024, 32'h0,           16'h0,    ORD_SAME,       4'd3, 2'd0, 32'h0000_ACE1},
    '{OP_WR,   16'h0028, 32'h0001_0005,   16'h0,    ORD_SAME,       4'd1, 2'd0, 32'h0},
    '{OP_RD,   16'h0028, 32'h0,           16'h0,    ORD_SAME,       4'd2, 2'd0, 32'h0000_0005},
    // error answers
    '{OP_RD,   16'h0040, 32'h0,           16'h0,    ORD_SAME,       4'd0, 2'd2, 32'h0},
    '{OP_RD,   16'h0000, 32'h0,           16'h0,    ORD_SAME,       4'd1, 2'd2, 32'h0},
    '{OP_WR,   16'h0004, 32'h1111_2222,   16'h0,    ORD_SAME,       4'd0, 2'd2, 32'h0},
    '{OP_RD,   16'h0004, 32'h0,           16'h0,    ORD_SAME,       4'd0, 2'd0, 32'hDA0C_0001},
    // contention on dac1 step, reader went last so the write lands first
    '{OP_BOTH, 16'h0028, 32'h0000_0009,   16'h0028, ORD_SAME,       4'd1, 2'd0, 32'h0000_0009},
    '{OP_RD,   16'h0028, 32'h0,           16'h0,    ORD_SAME,       4'd0, 2'd0, 32'h0000_0009}
};

`endif

// File: testbench/daq_top_tb.sv
`timescale 1ns/10ps

module daq_top_tb import axi_params_pkg::*, daq_params_pkg::*; ();

    `include "daq_tb_table.svh"

    localparam int BATCH_CYCLES = 150;
    localparam int WATCHDOG_CYCLES = N_ROWS * 64 + 2 * BATCH_CYCLES * 8 + 64;

    logic                                 ps_clk;
    logic                                 rst;
    logic [DAC_NUM-1:0]                   dac_rdys;
    logic [DAC_NUM-1:0][BATCH_WIDTH-1:0]  dac_batches;
    logic [DAC_NUM-1:0]                   valid_dac_batches;
    logic                                 pl_rstn;
    logic [A_BUS_WIDTH-1:0]               raddr_packet;
    logic                                 raddr_valid_packet;
    logic [A_BUS_WIDTH-1:0]               waddr_packet;
    logic                                 waddr_valid_packet;
    logic [WD_BUS_WIDTH-1:0]              wdata_packet;
    logic                                 wdata_valid_packet;
    logic                                 ps_wresp_rdy;
    logic                                 ps_read_rdy;
    logic [RESP_DATA_WIDTH-1:0]           wresp_out;
    logic                                 wresp_valid_out;
    logic [RESP_DATA_WIDTH-1:0]           rresp_out;
    logic                                 rresp_valid_out;
    logic [WD_BUS_WIDTH-1:0]              rdata_packet;
    logic                                 rdata_valid_out;

    integer seed = 32'ha59e0849;
    // batch checker and random ready enables
    logic   check_on;
    logic   rdy_random;
    logic [15:0] model_state [DAC_NUM];
    int     accepted [DAC_NUM];
    int     low_count;

    daq_top i_daq_top (.*);

    initial begin
        ps_clk = 1'b0;
        forever #2 ps_clk = ~ps_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ps_clk);
        $display("the run timed out waiting for the DUT");
        $display("Testbench failed");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // galois shift, right shifting with the taps on a one out
    function automatic logic [15:0] lfsr_shift(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    function automatic logic [63:0] model_batch(input int dac, input logic [15:0] s);
        logic [63:0] b;
        logic [15:0] l;
        l = s;
        for (int k = 0; k < 4; k++) begin
            if (dac == 0) begin
                b[k*16 +: 16] = s + 16'(k) * RAMP_STEP;
            end else begin
                l = lfsr_shift(l);
                b[k*16 +: 16] = l;
            end
        end
        return b;
    endfunction

    function automatic logic [15:0] model_next(input int dac, input logic [15:0] s);
        logic [63:0] b;
        if (dac == 0)
            return s + 16'd4 * RAMP_STEP;
        b = model_batch(dac, s);
        // lfsr continues from its fourth sample
        return b[63:48];
    endfunction

    // random dac ready pattern
    always @(posedge ps_clk) begin
        if (rdy_random)
            dac_rdys <= 2'($random(seed));
        else
            dac_rdys <= '0;
    end

    // compare batches at the falling edge, before the next accept
    always @(negedge ps_clk) begin
        if (check_on) begin
            for (int i = 0; i < DAC_NUM; i++) begin
                if (!pl_rstn) begin
                    check_value("valid_dac_batches", 64'(valid_dac_batches[i]), 64'd0);
                    model_state[i] = (i == 0) ? RAMP_SEED : LFSR_SEED;
                end else begin
                    check_value("valid_dac_batches", 64'(valid_dac_batches[i]), 64'd1);
                    check_value("dac_batches", dac_batches[i], model_batch(i, model_state[i]));
                    if (dac_rdys[i]) begin
                        model_state[i] = model_next(i, model_state[i]);
                        accepted[i]++;
                    end
                end
            end
        end
    end

    always @(negedge ps_clk) begin
        if (!rst && !pl_rstn)
            low_count++;
    end

    task automatic send_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [1:0] order);
        @(posedge ps_clk);
        if (order != ORD_DATA_FIRST) begin
            waddr_packet       <= addr;
            waddr_valid_packet <= 1'b1;
        end
        if (order != ORD_ADDR_FIRST) begin
            wdata_packet       <= data;
            wdata_valid_packet <= 1'b1;
        end
        if (order != ORD_SAME) begin
            @(posedge ps_clk);
            waddr_valid_packet <= (order == ORD_DATA_FIRST);
            wdata_valid_packet <= (order == ORD_ADDR_FIRST);
            waddr_packet       <= addr;
            wdata_packet       <= data;
        end
        @(posedge ps_clk);
        waddr_valid_packet <= 1'b0;
        wdata_valid_packet <= 1'b0;
    endtask

    task automatic send_read(input logic [15:0] addr);
        @(posedge ps_clk);
        raddr_packet       <= addr;
        raddr_valid_packet <= 1'b1;
        @(posedge ps_clk);
        raddr_valid_packet <= 1'b0;
    endtask

    task automatic send_both(input tb_row_t row);
        @(posedge ps_clk);
        waddr_packet       <= row.addr;
        wdata_packet       <= row.wdata;
        raddr_packet       <= row.raddr;
        waddr_valid_packet <= 1'b1;
        wdata_valid_packet <= 1'b1;
        raddr_valid_packet <= 1'b1;
        @(posedge ps_clk);
        waddr_valid_packet <= 1'b0;
        wdata_valid_packet <= 1'b0;
        raddr_valid_packet <= 1'b0;
    endtask

    // wait for the response, check it stays put, then accept it
    task automatic ack_write(input logic [1:0] exp_resp, input int delay);
        @(negedge ps_clk);
        while (!wresp_valid_out)
            @(negedge ps_clk);
        check_value("wresp_out", 64'(wresp_out), 64'(exp_resp));
        repeat (delay) begin
            @(negedge ps_clk);
            check_value("wresp_valid_out", 64'(wresp_valid_out), 64'd1);
            check_value("wresp_out", 64'(wresp_out), 64'(exp_resp));
        end
        @(posedge ps_clk);
        ps_wresp_rdy <= 1'b1;
        @(posedge ps_clk);
        ps_wresp_rdy <= 1'b0;
        @(negedge ps_clk);
        check_value("wresp_valid_out", 64'(wresp_valid_out), 64'd0);
    endtask

    task automatic ack_read(input logic [1:0] exp_resp, input logic [31:0] exp_data,
                            input int delay);
        @(negedge ps_clk);
        while (!rdata_valid_out)
            @(negedge ps_clk);
        check_value("rresp_valid_out", 64'(rresp_valid_out), 64'd1);
        check_value("rresp_out", 64'(rresp_out), 64'(exp_resp));
        check_value("rdata_packet", 64'(rdata_packet), 64'(exp_data));
        repeat (delay) begin
            @(negedge ps_clk);
            check_value("rdata_valid_out", 64'(rdata_valid_out), 64'd1);
            check_value("rresp_out", 64'(rresp_out), 64'(exp_resp));
            check_value("rdata_packet", 64'(rdata_packet), 64'(exp_data));
        end
        @(posedge ps_clk);
        ps_read_rdy <= 1'b1;
        @(posedge ps_clk);
        ps_read_rdy <= 1'b0;
        @(negedge ps_clk);
        check_value("rdata_valid_out", 64'(rdata_valid_out), 64'd0);
        check_value("rresp_valid_out", 64'(rresp_valid_out), 64'd0);
    endtask

    task automatic apply_row(input tb_row_t row);
        int delay;
        delay = int'(row.delay) + ($random(seed) & 3);
        case (row.op)
            OP_WR: begin
                send_write(row.addr, row.wdata, row.order);
                ack_write(row.exp_resp, delay);
            end
            OP_RD: begin
                send_read(row.addr);
                ack_read(row.exp_resp, row.exp_rdata, delay);
            end
            default: begin
                // read stays held while the write is answered
                send_both(row);
                ack_write(RESP_OKAY, delay);
                ack_read(row.exp_resp, row.exp_rdata, delay);
            end
        endcase
    endtask

    initial begin
        rst                = 1'b1;
        dac_rdys           = '0;
        raddr_packet       = '0;
        raddr_valid_packet = 1'b0;
        waddr_packet       = '0;
        waddr_valid_packet = 1'b0;
        wdata_packet       = '0;
        wdata_valid_packet = 1'b0;
        ps_wresp_rdy       = 1'b0;
        ps_read_rdy        = 1'b0;
        check_on           = 1'b0;
        rdy_random         = 1'b0;
        low_count          = 0;
        for (int i = 0; i < DAC_NUM; i++)
            accepted[i] = 0;
        repeat (3) @(posedge ps_clk);
        rst <= 1'b0;
        // idle outputs after reset
        @(negedge ps_clk);
        check_value("valid_dac_batches", 64'(valid_dac_batches), 64'd0);
        check_value("wresp_valid_out", 64'(wresp_valid_out), 64'd0);
        check_value("rdata_valid_out", 64'(rdata_valid_out), 64'd0);
        check_value("pl_rstn", 64'(pl_rstn), 64'd1);
        for (int r = 0; r < N_ROWS; r++)
            apply_row(ops_table[r]);
        // dac 0 ramp and dac 1 lfsr, both sitting on their seeds
        model_state[0] = RAMP_SEED;
        model_state[1] = LFSR_SEED;
        check_on   = 1'b1;
        rdy_random = 1'b1;
        repeat (BATCH_CYCLES) @(posedge ps_clk);
        check_true(accepted[0] > 0 && accepted[1] > 0, "no batch was accepted before reset");
        send_write(16'(ADDR_RST_CMD), 32'h1, ORD_SAME);
        ack_write(RESP_OKAY, 0);
        @(negedge ps_clk);
        while (!pl_rstn)
            @(negedge ps_clk);
        check_value("pl_rstn low cycles", 64'(low_count), 64'(PL_RST_CYCLES));
        accepted[0] = 0;
        accepted[1] = 0;
        repeat (BATCH_CYCLES) @(posedge ps_clk);
        check_true(accepted[0] > 0 && accepted[1] > 0, "no batch was accepted after reset");
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: daq_sys.f
+incdir+testbench
source/axi_params_pkg.sv
source/daq_params_pkg.sv
source/axi_write_slave.sv
source/axi_read_slave.sv
source/reg_bus_arbiter.sv
source/daq_reg_bank.sv
source/dac_sample_gen.sv
source/daq_top.sv
testbench/daq_top_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module daq_top_tb -Mdir obj_dir -f daq_sys.f
	./obj_dir/Vdaq_top_tb > sim.log 2>&1; cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
